// ==== common/glue_consts.svh ====
`ifndef GLUE_CONSTS_SVH
`define GLUE_CONSTS_SVH

// Address windows, byte addresses on the 24-bit bus
`define RAM_TOP 24'h3F_FFFF
`define ROM_BASE 24'h40_0000
`define ROM_TOP 24'h4F_FFFF

// Wait states added before nDTACK
`define ROM_WAIT 2
`define IO_WAIT 4 // Unmapped space

// Refresh timing in CLK cycles
`define REFRESH_PERIOD 64 // One refresh per period

// Request turns urgent here if not yet served
`define REFRESH_URGENT 24

// Both requests withdrawn here until the next period
`define REFRESH_WINDOW 40

`endif

// ==== common/GluePkg.sv ====
package GluePkg;

	// 68000 word address, A23..A1
	typedef logic [23:1] cpuAddr_t;

	// Multiplexed DRAM row/column address
	typedef logic [11:0] dramAddr_t;

	// One CPU bus phase as seen on the pins
	typedef struct packed {
		cpuAddr_t addr;
		logic nAS; // Address strobe
		logic nWE; // Low for write
		logic nLDS; // Lower byte strobe
		logic nUDS; // Upper byte strobe
	} cpuBus_t;

	// DRAM array control and address pins
	typedef struct packed {
		dramAddr_t ra;
		logic nRAS;
		logic nCAS;
		logic nLWE; // Lower byte write enable
		logic nUWE; // Upper byte write enable
		logic nOE;
	} dramBus_t;

	// NOR flash strobes
	typedef struct packed {
		logic nRomOE;
		logic nRomWE;
	} romCtl_t;

	// Refresh request pair from the period timer
	typedef struct packed {
		logic req; // Refresh wanted this period
		logic urg; // Refresh overdue, force it
	} refreshReq_t;

	// DRAM sequencer states, bit 2 marks refresh
	typedef enum logic [2:0] {
		Idle = 3'd0,
		Access = 3'd1, // Row latched, column driven
		AccessEnd = 3'd2, // Wait for acknowledge
		CycleDone = 3'd3,
		RefRas1 = 3'd4,
		RefRas2 = 3'd5,
		RefPre1 = 3'd6,
		RefPre2 = 3'd7
	} ramState_t;

endpackage

// ==== src/AddrDecode.sv ====
`timescale 1ns/10ps
`include "glue_consts.svh"

module AddrDecode (
	input logic CLK,
	input logic rst,
	input GluePkg::cpuBus_t cpu,
	input logic bact,
	output logic ramCs,
	output logic ramCs0X,
	output logic romCs
);

	import GluePkg::*;

	logic [23:0] byteAddr; // Full byte address, A0 forced low
	logic inRam;
	logic inRom;
	logic overlay; // ROM mirrored at zero

	assign byteAddr = {cpu.addr, 1'b0};

	// Window compares
	assign inRam = byteAddr <= `RAM_TOP;
	assign inRom = (byteAddr >= `ROM_BASE) && (byteAddr <= `ROM_TOP);

	// RAM window regardless of overlay
	assign ramCs0X = inRam;

	// Real RAM only once the overlay is gone
	assign ramCs = inRam && !overlay;

	// ROM proper, or its mirror at zero during boot
	assign romCs = inRom || (inRam && overlay);

	// Boot overlay flag
	always_ff @(posedge CLK) begin
		if (rst) begin
			overlay <= 1'b1; // CPU fetches vectors from ROM
		end else if (bact && inRom) begin
			overlay <= 1'b0; // First real ROM access drops it
		end
	end

endmodule

// ==== src/BusCycleTrack.sv ====
`timescale 1ns/10ps
`include "glue_consts.svh"

module BusCycleTrack (
	input logic CLK,
	input logic rst,
	input logic nAS,
	input logic ramCs,
	input logic romCs,
	input logic ramReady,
	output logic bact,
	output logic bactR,
	output logic nDTACK
);

	logic [2:0] waitCnt; // Wait states elapsed
	logic [2:0] waitLimit; // Wait states for this region

	// ROM or unmapped space, RAM uses ramReady
	assign waitLimit = romCs ? 3'(`ROM_WAIT) : 3'(`IO_WAIT);

	// nAS synchroniser and one-clock delay
	always_ff @(posedge CLK) begin
		if (rst) begin
			bact <= 1'b0;
			bactR <= 1'b0;
		end else begin
			bact <= !nAS;
			bactR <= bact;
		end
	end

	// Acknowledge generation
	always_ff @(posedge CLK) begin
		if (rst) begin
			nDTACK <= 1'b1;
			waitCnt <= '0;
		end else if (!bact) begin
			nDTACK <= 1'b1; // Release once the strobe is gone
			waitCnt <= '0;
		end else if (ramCs) begin
			if (ramReady)
				nDTACK <= 1'b0; // No wait unless refresh busy
		end else if (waitCnt == waitLimit) begin
			nDTACK <= 1'b0; // Held low until bact drops
		end else begin
			waitCnt <= waitCnt + 3'd1;
		end
	end

endmodule

// ==== src/RefreshTimer.sv ====
`timescale 1ns/10ps
`include "glue_consts.svh"

module RefreshTimer (
	input logic CLK,
	input logic rst,
	output GluePkg::refreshReq_t refresh
);

	import GluePkg::*;

	localparam int CntW = $clog2(`REFRESH_PERIOD);

	logic [CntW-1:0] periodCnt; // Position in refresh period
	logic lastCount;
	logic inWindow;
	logic pastUrgent;

	assign lastCount = periodCnt == CntW'(`REFRESH_PERIOD - 1);

	// Free-running period counter
	always_ff @(posedge CLK) begin
		if (rst) begin
			periodCnt <= '0;
		end else if (lastCount) begin
			periodCnt <= '0; // New period, new request
		end else begin
			periodCnt <= periodCnt + 1'b1;
		end
	end

	// Request open from period start to the window end
	assign inWindow = periodCnt < CntW'(`REFRESH_WINDOW);

	// Late part of the window
	assign pastUrgent = periodCnt >= CntW'(`REFRESH_URGENT);

	// Both requests withdrawn after the window so the
	// controller can rearm its done latch
	assign refresh.req = inWindow;
	assign refresh.urg = inWindow && pastUrgent;

endmodule

// ==== ram/RamCtrl.sv ====
`timescale 1ns/10ps

module RamCtrl (
	input logic CLK,
	input logic rst,
	input GluePkg::cpuBus_t cpu,
	input logic bact,
	input logic bactR,
	input logic ramCs,
	input logic ramCs0X,
	input logic romCs,
	input logic nDTACK,
	input GluePkg::refreshReq_t refresh,
	output logic ramReady,
	output GluePkg::dramBus_t dram,
	output GluePkg::romCtl_t rom
);

	import GluePkg::*;

	ramState_t state;
	ramState_t stateNext;
	cpuAddr_t a; // Shorthand for the CPU address
	dramAddr_t ra;
	logic dtackR; // Registered acknowledge
	logic rasSel; // Column address select
	logic rasEn; // RAS may follow nAS
	logic rasRR; // RAS held by rising-edge logic
	logic rasRF; // RAS held by falling-edge logic
	logic selNext;
	logic enNext;
	logic rrNext;
	logic readyNext;
	logic refDone; // This period's refresh served
	logic refActive;
	logic refReq;
	logic refUrg;
	logic toRef; // Start refresh from Idle
	logic nRas;
	logic nCas;
	logic nOe;
	logic nLwe;
	logic nUwe;

	assign a = cpu.addr;

	always_ff @(posedge CLK) begin
		if (rst)
			dtackR <= 1'b0;
		else
			dtackR <= !nDTACK;
	end

	// Refresh done latch, cleared when the timer withdraws
	assign refActive = state inside {RefRas1, RefRas2, RefPre1, RefPre2};
	always_ff @(posedge CLK) begin
		if (rst)
			refDone <= 1'b0;
		else if (!refresh.req && !refresh.urg)
			refDone <= 1'b0;
		else if (refActive)
			refDone <= 1'b1;
	end
	assign refReq = refresh.req && !refDone;
	assign refUrg = refresh.urg && !refDone;

	assign toRef = (refReq && bact && !bactR && !ramCs0X) || // First clock of non-RAM cycle
		(refUrg && !bact) || // Bus idle
		(refUrg && bact && !ramCs0X) || // Non-RAM cycle in progress
		(refUrg && !rasEn); // RAM access not allowed now

	// Next state and control values
	always_comb begin
		stateNext = state;
		selNext = 1'b0;
		enNext = 1'b0;
		rrNext = 1'b0;
		readyNext = 1'b1;
		case (state)
			Idle: begin
				if (toRef) begin
					stateNext = RefRas1; // CAS already low, raise RAS
					rrNext = 1'b1;
					readyNext = 1'b0;
				end else if (bact && ramCs && rasEn) begin
					stateNext = Access;
					selNext = 1'b1; // Switch to column
					rrNext = 1'b1; // Keep RAS after nAS path
					enNext = 1'b1;
				end else begin
					enNext = 1'b1;
				end
			end
			Access: begin
				stateNext = AccessEnd;
				selNext = 1'b1;
			end
			AccessEnd: begin
				if (dtackR)
					stateNext = CycleDone; // CPU saw the acknowledge
			end
			CycleDone: begin
				if (refUrg) begin
					stateNext = RefRas1;
					rrNext = 1'b1;
					readyNext = 1'b0;
				end else begin
					stateNext = Idle;
					enNext = 1'b1;
				end
			end
			RefRas1: begin
				stateNext = RefRas2;
				rrNext = 1'b1;
				readyNext = 1'b0;
			end
			RefRas2: begin
				stateNext = RefPre1; // RAS released
				readyNext = 1'b0;
			end
			RefPre1: begin
				stateNext = RefPre2;
				readyNext = 1'b0;
			end
			default: begin
				stateNext = Idle; // Reenable RAM
				enNext = 1'b1;
			end
		endcase
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= Idle;
			rasSel <= 1'b0;
			rasEn <= 1'b0;
			rasRR <= 1'b0;
			ramReady <= 1'b1;
		end else begin
			state <= stateNext;
			rasSel <= selNext;
			rasEn <= enNext;
			rasRR <= rrNext;
			ramReady <= readyNext;
		end
	end

	// Falling edge half: CAS and second RAS hold
	always_ff @(negedge CLK) begin
		if (rst) begin
			nCas <= 1'b1;
			rasRF <= 1'b0;
		end else begin
			rasRF <= state == Access;
			case (state)
				Idle: nCas <= !toRef; // CAS before RAS for refresh
				Access: nCas <= 1'b0;
				AccessEnd: nCas <= dtackR;
				CycleDone, RefRas1: nCas <= !refUrg;
				default: nCas <= 1'b1; // Precharge
			endcase
		end
	end

	// RAS falls straight off nAS for a fast row strobe
	assign nRas = !((!cpu.nAS && ramCs && rasEn) || rasRR || rasRF);
	assign nLwe = !(!cpu.nLDS && !cpu.nWE && rasSel);
	assign nUwe = !(!cpu.nUDS && !cpu.nWE && rasSel);

	// Output enable off once the acknowledged cycle winds down
	always_ff @(posedge CLK) begin
		if (rst)
			nOe <= 1'b1;
		else
			nOe <= !(bact && cpu.nWE && !(bactR && dtackR));
	end

	// Row/column mux, ROM A19 and A18 ride on ra[11] and ra[8]
	always_comb begin
		if (rasSel)
			ra = {a[20], a[7], a[8], a[21], a[6], a[5], a[4], a[3], a[20], a[7], a[2], a[1]};
		else
			ra = {a[19], a[17], a[15], a[18], a[14], a[13], a[12], a[11], a[19], a[16],
				a[10], a[9]};
	end

	assign dram = '{ra: ra, nRAS: nRas, nCAS: nCas, nLWE: nLwe, nUWE: nUwe, nOE: nOe};

	// Flash strobes follow nAS directly
	assign rom = '{nRomOE: !(romCs && !cpu.nAS && cpu.nWE),
		nRomWE: !(romCs && !cpu.nAS && !cpu.nWE)};

endmodule

// ==== src/GlueTop.sv ====
`timescale 1ns/10ps

module GlueTop (
	input logic CLK,
	input logic rst,
	input GluePkg::cpuBus_t cpu,
	output GluePkg::dramBus_t dram,
	output GluePkg::romCtl_t rom,
	output logic nDTACK
);

	import GluePkg::*;

	logic ramCs; // RAM with overlay off
	logic ramCs0X; // RAM window, any overlay
	logic romCs;
	logic bact; // Synchronised bus active
	logic bactR;
	logic ramReady; // Low while refreshing
	refreshReq_t refresh;

	AddrDecode addrDecode0 (
		.CLK(CLK),
		.rst(rst),
		.cpu(cpu),
		.bact(bact),
		.ramCs(ramCs),
		.ramCs0X(ramCs0X),
		.romCs(romCs)
	);

	BusCycleTrack busCycleTrack0 (
		.CLK(CLK),
		.rst(rst),
		.nAS(cpu.nAS),
		.ramCs(ramCs),
		.romCs(romCs),
		.ramReady(ramReady),
		.bact(bact),
		.bactR(bactR),
		.nDTACK(nDTACK)
	);

	RefreshTimer refreshTimer0 (
		.CLK(CLK),
		.rst(rst),
		.refresh(refresh)
	);

	RamCtrl ramCtrl0 (
		.CLK(CLK),
		.rst(rst),
		.cpu(cpu),
		.bact(bact),
		.bactR(bactR),
		.ramCs(ramCs),
		.ramCs0X(ramCs0X),
		.romCs(romCs),
		.nDTACK(nDTACK), // Acknowledge fed back to end the access
		.refresh(refresh),
		.ramReady(ramReady),
		.dram(dram),
		.rom(rom)
	);

endmodule

// ==== tb/ClkGen.sv ====
`timescale 1ns/10ps

module ClkGen (
	output logic CLK,
	output logic rst
);

	// 4 ns period clock
	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	// Reset held for two rising edges
	initial begin
		rst = 1'b1;
		repeat (2) @(posedge CLK);
		#1 rst = 1'b0; // Released off the edge like other inputs
	end

endmodule

// ==== tb/GlueAsserts.sv ====
`timescale 1ns/10ps

module GlueAsserts (
	input logic CLK,
	input logic rst,
	input GluePkg::ramState_t state,
	input logic nCas,
	input logic ramReady
);

	import GluePkg::*;

	// Sequencer comes out of reset in Idle
	resetIdle: assert property (@(posedge CLK) rst |=> state == Idle)
		else $error("RamCtrl state not Idle after reset");

	// CAS stays high through both precharge states
	casPrecharge: assert property (@(posedge CLK) disable iff (rst)
		(state == RefPre1 || state == RefPre2) |-> nCas)
		else $error("nCAS low during refresh precharge");

	// Bus must stall while any refresh state is active
	readyRefresh: assert property (@(posedge CLK) disable iff (rst)
		(state inside {RefRas1, RefRas2, RefPre1, RefPre2}) |-> !ramReady)
		else $error("ramReady high during refresh");

endmodule

// ==== tb/GlueChecker.sv ====
`timescale 1ns/10ps
`include "glue_consts.svh"

module GlueChecker (
	input logic CLK,
	input logic rst,
	input GluePkg::cpuBus_t cpu,
	input GluePkg::dramBus_t dram,
	input GluePkg::romCtl_t rom,
	input logic nDTACK,
	output int errCnt,
	output int busCycles,
	output int periods
);

	import GluePkg::*;

	localparam int RegRam = 0;
	localparam int RegRom = 1;
	localparam int RegIo = 2;

	logic prevRas, prevCas, prevNAS, prev2NAS;
	logic rasFell, casFell;
	logic inCycle;
	logic overlayExp; // Expected boot overlay
	logic refBusy; // Refresh in progress on the pins
	logic cycWrite;
	cpuAddr_t cycAddr;
	int region;
	int ackCnt; // Clocks since nAS fell
	logic ackSeen;
	int accRas, accCas; // Access strobes this cycle
	int dtLow; // nDTACK low with nAS high
	int tick; // Mirror of the refresh period
	int refInPeriod;

	// Row half of the DRAM address
	function automatic dramAddr_t rowOf(input cpuAddr_t a);
		dramAddr_t r;
		r[11] = a[19];
		r[10] = a[17];
		r[9] = a[15];
		r[8] = a[18];
		r[7:4] = a[14:11];
		r[3] = a[19];
		r[2] = a[16];
		r[1:0] = a[10:9];
		return r;
	endfunction

	// Column half of the DRAM address
	function automatic dramAddr_t colOf(input cpuAddr_t a);
		dramAddr_t c;
		c[11] = a[20];
		c[10] = a[7];
		c[9] = a[8];
		c[8] = a[21];
		c[7:4] = a[6:3];
		c[3] = a[20];
		c[2] = a[7];
		c[1:0] = a[2:1];
		return c;
	endfunction

	// Expected select for an address and overlay state
	function automatic int regionOf(input cpuAddr_t a, input logic ovl);
		logic [23:0] b;
		b = {a, 1'b0};
		if (b <= `RAM_TOP)
			return ovl ? RegRom : RegRam; // Mirror of ROM at zero
		if (b >= `ROM_BASE && b <= `ROM_TOP)
			return RegRom;
		return RegIo;
	endfunction

	function automatic logic inRomWindow(input cpuAddr_t a);
		logic [23:0] b;
		b = {a, 1'b0};
		return b >= `ROM_BASE && b <= `ROM_TOP;
	endfunction

	task automatic reportError(input string msg);
		$display("FAILED @%0t: %s", $time, msg);
		errCnt++;
	endtask

	initial begin
		errCnt = 0;
		busCycles = 0;
		periods = 0;
	end

	always @(posedge CLK) begin
		if (rst) begin
			prevRas = 1'b1;
			prevCas = 1'b1;
			prevNAS = 1'b1;
			prev2NAS = 1'b1;
			inCycle = 1'b0;
			overlayExp = 1'b1; // Overlay set by reset
			refBusy = 1'b0;
			dtLow = 0;
			tick = 0;
			refInPeriod = 0;
		end else begin
			rasFell = prevRas && !dram.nRAS;
			casFell = prevCas && !dram.nCAS;

			// Bus cycle start, region fixed here
			if (!cpu.nAS && prevNAS) begin
				inCycle = 1'b1;
				cycAddr = cpu.addr;
				cycWrite = !cpu.nWE;
				region = regionOf(cpu.addr, overlayExp);
				if (inRomWindow(cpu.addr))
					overlayExp = 1'b0;
				ackCnt = 0;
				ackSeen = 1'b0;
				accRas = 0;
				accCas = 0;
			end else if (inCycle && !cpu.nAS) begin
				ackCnt++;
			end

			// Wait-state count for ROM and unmapped space
			if (inCycle && !cpu.nAS && !nDTACK && !ackSeen) begin
				ackSeen = 1'b1;
				if (region == RegRom && ackCnt != `ROM_WAIT + 2)
					reportError($sformatf("ROM ack after %0d clocks", ackCnt));
				if (region == RegIo && ackCnt != `IO_WAIT + 2)
					reportError($sformatf("IO ack after %0d clocks", ackCnt));
			end

			// Flash strobes and ROM address bits
			if (inCycle && !cpu.nAS) begin
				if (rom.nRomOE != !(region == RegRom && cpu.nWE))
					reportError($sformatf("nRomOE %b at %h", rom.nRomOE, cycAddr));
				if (rom.nRomWE != !(region == RegRom && !cpu.nWE))
					reportError($sformatf("nRomWE %b at %h", rom.nRomWE, cycAddr));
				if (region == RegRom && (dram.ra[11] != cycAddr[19] ||
					dram.ra[8] != cycAddr[18]))
					reportError($sformatf("ROM bank bits ra %h addr %h", dram.ra, cycAddr));
			end else if (!rom.nRomOE || !rom.nRomWE) begin
				reportError("ROM strobe active outside a bus cycle");
			end

			// Classify strobe edges
			if (rasFell && casFell) begin
				refInPeriod++; // CAS with RAS in one step, still a refresh
				refBusy = 1'b1;
			end else if (casFell && dram.nRAS) begin
				refInPeriod++; // CAS before RAS
				refBusy = 1'b1;
			end else if (rasFell && dram.nCAS && !refBusy) begin
				if (!inCycle || region != RegRam) begin
					reportError("nRAS access outside a RAM cycle");
				end else begin
					accRas++;
					if (dram.ra != rowOf(cycAddr))
						reportError($sformatf("row %h expected %h", dram.ra, rowOf(cycAddr)));
				end
			end else if (casFell && !refBusy) begin
				if (!inCycle || region != RegRam) begin
					reportError("nCAS access outside a RAM cycle");
				end else begin
					accCas++;
					if (dram.ra != colOf(cycAddr))
						reportError($sformatf("col %h expected %h", dram.ra, colOf(cycAddr)));
					if (cycWrite && (dram.nLWE != cpu.nLDS || dram.nUWE != cpu.nUDS))
						reportError($sformatf("write enables %b%b", dram.nUWE, dram.nLWE));
					if (!cycWrite && (!dram.nLWE || !dram.nUWE))
						reportError("write enable low on a read");
					if (dram.nOE != cycWrite)
						reportError($sformatf("nOE %b on access", dram.nOE));
				end
			end

			// Quiet data strobes while refreshing
			if (refBusy) begin
				if (!dram.nLWE || !dram.nUWE)
					reportError("write enable low during refresh");
				if (!dram.nOE && cpu.nAS && prevNAS && prev2NAS)
					reportError("nOE low during refresh with bus idle");
				if (dram.nCAS && dram.nRAS)
					refBusy = 1'b0;
			end

			// Cycle end, one access for RAM and none elsewhere
			if (inCycle && cpu.nAS && !prevNAS) begin
				if (region == RegRam && (accRas != 1 || accCas != 1))
					reportError($sformatf("RAM cycle at %h had %0d RAS, %0d CAS",
						cycAddr, accRas, accCas));
				if (region != RegRam && (accRas != 0 || accCas != 0))
					reportError($sformatf("non-RAM cycle at %h strobed DRAM", cycAddr));
				inCycle = 1'b0;
				busCycles++;
			end

			// Acknowledge released after nAS rises
			if (cpu.nAS && !nDTACK) begin
				dtLow++;
				if (dtLow > 2)
					reportError("nDTACK held low after nAS rose");
			end else begin
				dtLow = 0;
			end

			// One refresh per period
			if (tick == `REFRESH_PERIOD - 1) begin
				if (refInPeriod != 1)
					reportError($sformatf("%0d refreshes in period", refInPeriod));
				refInPeriod = 0;
				tick = 0;
				periods++;
			end else begin
				tick++;
			end

			prevRas = dram.nRAS;
			prevCas = dram.nCAS;
			prev2NAS = prevNAS;
			prevNAS = cpu.nAS;
		end
	end

endmodule

// ==== tb/GlueTb.sv ====
`timescale 1ns/10ps
`include "glue_consts.svh"

module GlueTb;

	import GluePkg::*;

	localparam int NumCycles = 200;
	localparam int TimeoutLimit = NumCycles * (`IO_WAIT + 8 + 6) + 2 * `REFRESH_PERIOD;

	logic CLK;
	logic rst;
	cpuBus_t cpu;
	dramBus_t dram;
	romCtl_t rom;
	logic nDTACK;
	int errCnt;
	int busCycles;
	int periods;
	int clkCnt; // Timeout counter

	ClkGen clkGen0 (.CLK(CLK), .rst(rst));

	GlueTop dut0 (
		.CLK(CLK),
		.rst(rst),
		.cpu(cpu),
		.dram(dram),
		.rom(rom),
		.nDTACK(nDTACK)
	);

	GlueChecker checker0 (
		.CLK(CLK),
		.rst(rst),
		.cpu(cpu),
		.dram(dram),
		.rom(rom),
		.nDTACK(nDTACK),
		.errCnt(errCnt),
		.busCycles(busCycles),
		.periods(periods)
	);

	bind RamCtrl GlueAsserts asserts0 (
		.CLK(CLK),
		.rst(rst),
		.state(state),
		.nCas(nCas),
		.ramReady(ramReady)
	);

	// Random address in RAM, ROM or unmapped space
	function automatic cpuAddr_t pickAddr();
		logic [23:0] b;
		int kind;
		kind = $urandom_range(0, 9);
		if (kind < 5)
			b = 24'($urandom) & 24'h3F_FFFE; // RAM window
		else if (kind < 8)
			b = `ROM_BASE | (24'($urandom) & 24'h0F_FFFE);
		else
			b = {4'(5 + $urandom_range(0, 10)), 20'($urandom) & 20'hF_FFFE};
		return b[23:1];
	endfunction

	// One 68000 cycle, ends when the acknowledge is seen
	task automatic runBusCycle(input cpuAddr_t addr, input logic wr, input logic [1:0] strb);
		cpu.addr = addr;
		cpu.nWE = !wr;
		cpu.nUDS = strb[1];
		cpu.nLDS = strb[0];
		cpu.nAS = 1'b0;
		do begin
			@(posedge CLK);
			#1;
		end while (nDTACK);
		@(posedge CLK); // CPU closes the cycle a clock after the acknowledge
		#1;
		cpu.nAS = 1'b1; // Address held until next cycle
		cpu.nUDS = 1'b1;
		cpu.nLDS = 1'b1;
		while (!nDTACK) begin
			@(posedge CLK);
			#1;
		end
	endtask

	initial begin
		logic wr;
		logic [1:0] strb;
		int gap;
		cpuAddr_t addr;
		cpu = '{addr: '0, nAS: 1'b1, nWE: 1'b1, nLDS: 1'b1, nUDS: 1'b1};
		void'($urandom(32'h3d45b46e));
		@(negedge rst);
		@(posedge CLK);
		#1;
		for (int i = 0; i < NumCycles; i++) begin
			wr = 1'($urandom_range(0, 1));
			case ($urandom_range(0, 2))
				0: strb = 2'b01; // Upper byte only
				1: strb = 2'b10;
				default: strb = 2'b00;
			endcase
			if (!wr)
				strb = 2'b00; // Word reads
			addr = pickAddr();
			if (i == 0)
				addr[23:22] = 2'b00; // RAM window while the overlay is on
			runBusCycle(addr, wr, strb);
			gap = $urandom_range(0, 3);
			repeat (gap) begin
				@(posedge CLK);
				#1;
			end
		end
		repeat (4) @(posedge CLK);
		$display("Summary: %0d bus cycles, %0d refresh periods, %0d errors",
			busCycles, periods, errCnt);
		if (errCnt == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// Run limit from the cycle budget
	initial clkCnt = 0;
	always @(posedge CLK) begin
		clkCnt++;
		if (clkCnt >= TimeoutLimit) begin
			$display("timeout: bus cycles did not finish");
			$display("RESULT: FAIL");
			$finish;
		end
	end

endmodule

// ==== sim.f ====
+incdir+common
common/GluePkg.sv
src/AddrDecode.sv
src/BusCycleTrack.sv
src/RefreshTimer.sv
ram/RamCtrl.sv
src/GlueTop.sv
tb/ClkGen.sv
tb/GlueAsserts.sv
tb/GlueChecker.sv
tb/GlueTb.sv

// ==== Makefile ====
TOP = GlueTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o Vsim
	./obj_dir/Vsim | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
